// ==== build.f ====
common/downscale_pkg.sv
common/pix_wr_if.sv
capture/video_decimator.sv
framebuf/frame_buffer.sv
source/video_downscale_top.sv
sim/video_src_model.sv
sim/tb_video_downscale.sv

// ==== capture/video_decimator.sv ====
`timescale 1ns/1ns

module video_decimator (
  input  logic                  i_Clk3x,
  input  logic                  i_rst_n,
  input  logic                  i_hsync,
  input  logic                  i_vsync,
  input  logic                  i_vde,
  input  downscale_pkg::pixel_t i_pixel,
  pix_wr_if.producer            wr,
  output logic                  o_capturing
);
  import downscale_pkg::*;

  // phase counter widths follow the ratios
  typedef logic [$clog2(PIX_DIV)-1:0]   pix_ph_t;
  typedef logic [$clog2(LINE_DIV)-1:0]  line_ph_t;
  typedef logic [$clog2(FRAME_DIV)-1:0] frame_ph_t;

  // sampled inputs, syncs turned active high
  logic       hs_q;
  logic       vs_q;
  logic       vs_d;
  logic       vde_q;
  logic       vde_d;
  pixel_t     pix_q;
  pixel_t     hold_pix;

  cap_state_t state;
  frame_ph_t  frame_ph;
  line_ph_t   line_ph;
  pix_ph_t    pix_ph;
  out_col_t   col;
  out_row_t   row;

  logic       vs_start;
  logic       vde_rise;
  logic       line_end;
  logic       in_kept;
  logic       keep_line;
  logic       pix_act;
  logic       capture;
  logic       issue;
  logic       end_pend;

  //////////////////////////////////////////////////
  // input sampling and edge detect
  //////////////////////////////////////////////////

  always_ff @(posedge i_Clk3x or negedge i_rst_n) begin
    if (!i_rst_n) begin
      hs_q  <= 1'b0;
      vs_q  <= 1'b0;
      vs_d  <= 1'b0;
      vde_q <= 1'b0;
      vde_d <= 1'b0;
    end else begin
      // sync inputs arrive active low
      hs_q  <= ~i_hsync;
      vs_q  <= ~i_vsync;
      vs_d  <= vs_q;
      vde_q <= i_vde;
      vde_d <= vde_q;
    end
  end

  // falling edge of i_vsync starts a frame
  assign vs_start  = vs_q & ~vs_d;
  // first active pixel of a line
  assign vde_rise  = vde_q & ~vde_d;
  // active region over, or hsync cut it short
  assign line_end  = ~vde_q | hs_q;

  assign in_kept   = (state == LINE_GAP) || (state == LINE_KEEP) || (state == LINE_DROP);
  // line index in frame a multiple of LINE_DIV, and rows left
  assign keep_line = (line_ph == '0) && (row < OUT_ROWS);

  // pixel counts inside a kept line, including its very first sample
  assign pix_act = !line_end && !vs_start &&
                   ((state == LINE_KEEP) || ((state == LINE_GAP) && vde_rise && keep_line));
  // phase 0 grabs the pixel, last phase writes it
  assign capture = pix_act && (pix_ph == '0) && (col < OUT_COLS);
  assign issue   = pix_act && (pix_ph == pix_ph_t'(PIX_DIV - 1)) && (col < OUT_COLS);

  assign o_capturing = in_kept;

  //////////////////////////////////////////////////
  // capture fsm and decimation counters
  //////////////////////////////////////////////////

  always_ff @(posedge i_Clk3x or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= WAIT_FRAME;
      frame_ph <= '0;
      line_ph  <= '0;
      pix_ph   <= '0;
      col      <= '0;
      row      <= '0;
    end else begin
      if (vs_start) begin
        // new frame, first one after reset has phase 0 and is kept
        state    <= (frame_ph == '0) ? LINE_GAP : SKIP_FRAME;
        frame_ph <= (frame_ph == frame_ph_t'(FRAME_DIV - 1)) ? '0 : frame_ph + 1'b1;
        line_ph  <= '0;
        row      <= '0;
      end else begin
        case (state)
          LINE_GAP: begin
            // line decision at the vde rise
            if (vde_rise && !hs_q) begin
              state   <= keep_line ? LINE_KEEP : LINE_DROP;
              line_ph <= (line_ph == line_ph_t'(LINE_DIV - 1)) ? '0 : line_ph + 1'b1;
            end
          end
          LINE_KEEP: begin
            if (line_end) begin
              state <= LINE_GAP;
              row   <= row + 1'b1;
            end
          end
          LINE_DROP: begin
            if (line_end) begin
              state <= LINE_GAP;
            end
          end
          // waiting or skipping, only a vsync moves on
          default: begin
            state <= state;
          end
        endcase
      end

      // per-line pixel phase and output column
      if (pix_act) begin
        pix_ph <= (pix_ph == pix_ph_t'(PIX_DIV - 1)) ? '0 : pix_ph + 1'b1;
        if (issue) begin
          col <= col + 1'b1;
        end
      end else if (state != LINE_KEEP) begin
        pix_ph <= '0;
        col    <= '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // write strobes
  //////////////////////////////////////////////////

  always_ff @(posedge i_Clk3x or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr.wr_en     <= 1'b0;
      end_pend     <= 1'b0;
      wr.frame_end <= 1'b0;
    end else begin
      wr.wr_en     <= issue;
      // only a kept frame reports its end, two clocks after the vsync sample
      end_pend     <= vs_start && in_kept;
      wr.frame_end <= end_pend;
    end
  end

  // pixel path
  always_ff @(posedge i_Clk3x) begin
    pix_q <= i_pixel;
    if (capture) begin
      hold_pix <= pix_q;
    end
    if (issue) begin
      wr.wr_pixel <= hold_pix;
      // row-major, row and col already clipped
      wr.wr_addr  <= fb_addr_t'(int'(row) * OUT_COLS + int'(col));
    end
  end

endmodule

// ==== common/downscale_pkg.sv ====
package downscale_pkg;

  //////////////////////////////////////////////////
  // reduced image geometry
  //////////////////////////////////////////////////

  // stored pixels per kept line
  localparam int OUT_COLS = 16;
  // stored lines per kept frame
  localparam int OUT_ROWS = 8;
  // one full reduced frame
  localparam int FB_DEPTH = OUT_COLS * OUT_ROWS;

  //////////////////////////////////////////////////
  // decimation ratios
  //////////////////////////////////////////////////

  // one active pixel in four
  localparam int PIX_DIV   = 4;
  // one active line in four
  localparam int LINE_DIV  = 4;
  // one frame in three
  localparam int FRAME_DIV = 3;

  // rgb888, red in [23:16], green in [15:8], blue in [7:0]
  typedef logic [23:0] pixel_t;
  // row-major frame buffer index
  typedef logic [6:0]  fb_addr_t;
  // output column, one bit wider so it can reach OUT_COLS
  typedef logic [4:0]  out_col_t;
  // output row, reaches OUT_ROWS when the frame is full
  typedef logic [3:0]  out_row_t;

  // capture fsm
  typedef enum logic [2:0] {
    WAIT_FRAME,
    SKIP_FRAME,
    LINE_GAP,
    LINE_KEEP,
    LINE_DROP
  } cap_state_t;

endpackage

// ==== common/pix_wr_if.sv ====
`timescale 1ns/1ns

interface pix_wr_if;
  import downscale_pkg::*;

  // single-cycle write strobe, always accepted
  logic     wr_en;
  // row * OUT_COLS + column
  fb_addr_t wr_addr;
  // pixel that goes with wr_en
  pixel_t   wr_pixel;
  // end of a kept frame, one cycle
  logic     frame_end;

  // decimator side
  modport producer (output wr_en, output wr_addr, output wr_pixel, output frame_end);

  // memory side
  modport consumer (input wr_en, input wr_addr, input wr_pixel, input frame_end);

endinterface

// ==== framebuf/frame_buffer.sv ====
`timescale 1ns/1ns

module frame_buffer (
  input  logic                    i_Clk3x,
  pix_wr_if.consumer              wr,
  input  downscale_pkg::fb_addr_t i_rd_addr,
  output downscale_pkg::pixel_t   o_rd_pixel
);
  import downscale_pkg::*;

  //////////////////////////////////////////////////
  // one reduced frame of rgb888
  //////////////////////////////////////////////////

  // row-major, entry = row * OUT_COLS + col
  pixel_t mem [FB_DEPTH];

  // write port
  // one pixel per strobe, never stalls
  always_ff @(posedge i_Clk3x) begin
    if (wr.wr_en) begin
      mem[wr.wr_addr] <= wr.wr_pixel;
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////

  // one clock latency
  // same-cycle read of a written address returns old contents
  always_ff @(posedge i_Clk3x) begin
    o_rd_pixel <= mem[i_rd_addr];
  end

endmodule

// ==== sim/tb_video_downscale.sv ====
`timescale 1ns/1ns

module tb_video_downscale;
  import downscale_pkg::*;

  logic     clk;
  logic     rst_n;
  logic     hsync;
  logic     vsync;
  logic     vde;
  pixel_t   pixel;
  fb_addr_t rd_addr;
  pixel_t   rd_pixel;
  logic     frame_done;
  logic     capturing;

  int       fails;
  int       tests_ok;
  int       tests_bad;
  int       cyc;
  int       vs_fall_cyc;
  int       done_cyc;
  int       done_cnt;
  logic     vs_prev;
  logic     seen_vs;
  // frames 2 and 3 are skipped, nothing may report
  logic     quiet;
  pixel_t   ref_img [FB_DEPTH];

  video_downscale_top dut (
    .i_Clk3x      (clk),
    .i_rst_n      (rst_n),
    .i_hsync      (hsync),
    .i_vsync      (vsync),
    .i_vde        (vde),
    .i_pixel      (pixel),
    .i_rd_addr    (rd_addr),
    .o_rd_pixel   (rd_pixel),
    .o_frame_done (frame_done),
    .o_capturing  (capturing)
  );

  video_src_model src (.i_clk(clk), .o_hsync(hsync), .o_vsync(vsync), .o_vde(vde), .o_pixel(pixel));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // cycle stamps of vsync falls and done pulses
  always @(posedge clk) begin
    cyc     <= cyc + 1;
    vs_prev <= vsync;
    if (!rst_n) seen_vs <= 1'b0;
    else if (vs_prev && !vsync) begin
      seen_vs     <= 1'b1;
      vs_fall_cyc <= cyc;
    end
    if (frame_done) begin
      done_cnt <= done_cnt + 1;
      done_cyc <= cyc;
    end
  end

  task automatic log_error(input string msg);
    fails++;
    $display("%s", msg);
  endtask

  //////////////////////////////////////////////////
  // concurrent checks
  //////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge clk) !rst_n |-> !capturing && !frame_done)
    else log_error("status outputs high during reset");
  a_no_early: assert property (@(posedge clk) !seen_vs |-> !capturing && !frame_done)
    else log_error("status output rose before the first vsync fall");
  a_one_cycle: assert property (@(posedge clk) frame_done |=> !frame_done)
    else log_error("frame done pulse longer than one clock");
  a_quiet: assert property (@(posedge clk) quiet |-> !capturing && !frame_done)
    else log_error("activity seen during a skipped frame");

  task automatic wait_done();
    int cnt0;
    int t;
    cnt0 = done_cnt;
    t    = 0;
    while ((done_cnt == cnt0) && (t <= 200)) begin
      @(negedge clk);
      t++;
    end
    if (done_cnt == cnt0) begin
      $display("timeout waiting for the frame done pulse");
      $display("TB FAILED");
      $finish;
    end else begin
      repeat (4) @(negedge clk);
      // rises on the third edge after the edge that samples the vsync fall
      assert (done_cyc == vs_fall_cyc + 4)
        else log_error($sformatf("FAILED o_frame_done cycle: expected %h got %h",
                                 vs_fall_cyc + 4, done_cyc));
      assert (done_cnt == cnt0 + 1)
        else log_error($sformatf("FAILED o_frame_done count: expected %h got %h",
                                 cnt0 + 1, done_cnt));
    end
  endtask

  task automatic check_buffer();
    for (int a = 0; a < FB_DEPTH; a++) begin
      rd_addr = fb_addr_t'(a);
      @(negedge clk);
      assert (rd_pixel === ref_img[a])
        else log_error($sformatf("FAILED o_rd_pixel[%h]: expected %h got %h",
                                 a, ref_img[a], rd_pixel));
    end
  endtask

  task automatic take_expected();
    for (int a = 0; a < FB_DEPTH; a++) ref_img[a] = src.exp_img[a];
  endtask

  task automatic end_test(input string name, input int fails0);
    if (fails == fails0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, fails - fails0);
    end
  endtask

  task automatic do_reset();
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  endtask

  initial begin
    int f0;
    int d0;
    fails       = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    cyc         = 0;
    done_cnt    = 0;
    done_cyc    = 0;
    vs_fall_cyc = 0;
    vs_prev     = 1'b1;
    seen_vs     = 1'b0;
    quiet       = 1'b0;
    rst_n       = 1'b0;
    rd_addr     = '0;

    f0 = fails;
    do_reset();
    repeat (20) @(negedge clk);
    end_test("reset", f0);

    f0 = fails;
    src.send_vsync();
    src.send_lines(36);
    take_expected();
    src.send_vsync();
    wait_done();
    check_buffer();
    end_test("first frame", f0);

    // frames 2 and 3 skipped, buffer keeps frame 1
    f0 = fails;
    d0 = done_cnt;
    quiet = 1'b1;
    src.send_lines(36);
    src.send_vsync();
    src.send_lines(36);
    quiet = 1'b0;
    // vsync that ends frame 3 opens frame 4
    src.send_vsync();
    check_buffer();
    // no pulse at the end of either skipped frame
    assert (done_cnt == d0)
      else log_error($sformatf("FAILED o_frame_done count: expected %h got %h",
                               d0, done_cnt));
    end_test("skipped frames", f0);

    f0 = fails;
    src.send_lines(36);
    take_expected();
    src.send_vsync();
    wait_done();
    check_buffer();
    end_test("fourth frame", f0);

    f0 = fails;
    do_reset();
    src.send_vsync();
    src.send_lines(18);
    assert (capturing === 1'b1)
      else log_error($sformatf("FAILED o_capturing: expected 1 got %h", capturing));
    rst_n = 1'b0;
    #1;
    assert (capturing === 1'b0)
      else log_error($sformatf("FAILED o_capturing: expected 0 got %h", capturing));
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    src.send_vsync();
    src.send_lines(36);
    take_expected();
    src.send_vsync();
    wait_done();
    check_buffer();
    end_test("mid-frame reset", f0);

    $display("tests passed %0d failed %0d, check errors %0d", tests_ok, tests_bad, fails);
    if (fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/video_src_model.sv ====
`timescale 1ns/1ns

module video_src_model (
  input  logic                  i_clk,
  output logic                  o_hsync,
  output logic                  o_vsync,
  output logic                  o_vde,
  output downscale_pkg::pixel_t o_pixel
);
  import downscale_pkg::*;

  // raster of the source video, both larger than the clip window
  localparam int ACT_W  = 72;
  localparam int ACT_H  = 36;
  localparam int HS_LEN = 4;
  localparam int H_BP   = 4;
  localparam int H_FP   = 6;
  localparam int V_BP   = 3;
  localparam int V_FP   = 2;

  logic [31:0] rng;
  // reduced image that the decimation rule predicts
  pixel_t      exp_img [FB_DEPTH];

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    rng     = 32'h16c;
    o_hsync = 1'b1;
    o_vsync = 1'b1;
    o_vde   = 1'b0;
    o_pixel = '0;
  end

  // one line, hsync then porches around the active run
  task automatic send_line(input int line, input bit active);
    for (int p = 0; p < HS_LEN + H_BP + ACT_W + H_FP; p++) begin
      @(negedge i_clk);
      o_hsync = (p >= HS_LEN);
      o_vde   = active && (p >= HS_LEN + H_BP) && (p < HS_LEN + H_BP + ACT_W);
      o_pixel = '0;
      if (o_vde) begin
        rng     = xorshift32(rng);
        o_pixel = rng[23:0];
        // kept line, kept pixel, inside the clip window
        if ((line % LINE_DIV == 0) && ((p - HS_LEN - H_BP) % PIX_DIV == 0) &&
            (line / LINE_DIV < OUT_ROWS) && ((p - HS_LEN - H_BP) / PIX_DIV < OUT_COLS)) begin
          exp_img[(line / LINE_DIV) * OUT_COLS + (p - HS_LEN - H_BP) / PIX_DIV] = rng[23:0];
        end
      end
    end
  endtask

  // vsync low for two clocks, the fall starts a frame
  task automatic send_vsync();
    @(negedge i_clk);
    o_vsync = 1'b0;
    @(negedge i_clk);
    @(negedge i_clk);
    o_vsync = 1'b1;
  endtask

  task automatic send_lines(input int n_lines);
    for (int l = 0; l < V_BP; l++) send_line(l, 1'b0);
    for (int l = 0; l < n_lines; l++) send_line(l, 1'b1);
    for (int l = 0; l < V_FP; l++) send_line(l, 1'b0);
  endtask

endmodule

// ==== source/video_downscale_top.sv ====
`timescale 1ns/1ns

module video_downscale_top (
  input  logic                    i_Clk3x,
  input  logic                    i_rst_n,
  // parallel video in, syncs active low
  input  logic                    i_hsync,
  input  logic                    i_vsync,
  input  logic                    i_vde,
  input  downscale_pkg::pixel_t   i_pixel,
  // buffer readback
  input  downscale_pkg::fb_addr_t i_rd_addr,
  output downscale_pkg::pixel_t   o_rd_pixel,
  // status
  output logic                    o_frame_done,
  output logic                    o_capturing
);

  //////////////////////////////////////////////////
  // decimator to buffer link
  //////////////////////////////////////////////////

  pix_wr_if wr_bus ();

  // sync polarity, frame/line/pixel decimation, write addressing
  video_decimator u_decimator (
    .i_Clk3x     (i_Clk3x),
    .i_rst_n     (i_rst_n),
    .i_hsync     (i_hsync),
    .i_vsync     (i_vsync),
    .i_vde       (i_vde),
    .i_pixel     (i_pixel),
    .wr          (wr_bus.producer),
    .o_capturing (o_capturing)
  );

  // reduced frame store
  frame_buffer u_frame_buffer (
    .i_Clk3x    (i_Clk3x),
    .wr         (wr_bus.consumer),
    .i_rd_addr  (i_rd_addr),
    .o_rd_pixel (o_rd_pixel)
  );

  //////////////////////////////////////////////////
  // frame done
  //////////////////////////////////////////////////

  // frame_end plus one register, three clocks after the vsync sample
  always_ff @(posedge i_Clk3x or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_frame_done <= 1'b0;
    end else begin
      o_frame_done <= wr_bus.frame_end;
    end
  end

endmodule
